//--- logic/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry, one cache per processor port
`define LINE_BYTES 16  // bytes per line
`define NUM_SETS 8     // sets per cache

// shared backing store
`define MEM_LINES 64   // lines in the line memory
`define MEM_LATENCY 4  // cycles from accept to completion

`endif

//--- logic/cache_pkg.sv
package cache_pkg;

  // processor side address and data
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // address fields: tag 31..7, set 6..4, word 3..2
  typedef logic [24:0] tag_t;
  typedef logic [2:0] set_idx_t;
  typedef logic [1:0] word_off_t;

  typedef logic way_t;  // two ways only

  typedef enum logic [1:0] {
    idle,
    compare_tag,
    write_back,
    allocate
  } cache_state_t;

endpackage

//--- logic/mem_pkg.sv
`include "cache_params.svh"

package mem_pkg;

  typedef logic [`LINE_BYTES*8-1:0] line_t;
  typedef logic [27:0] line_addr_t;  // byte address >> 4

  typedef logic req_id_t;  // 0 = port a, 1 = port b

  typedef enum logic {
    arb_idle,
    arb_busy
  } arb_state_t;

  typedef enum logic {
    mem_idle,
    mem_busy
  } mem_state_t;

endpackage

//--- logic/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_ctrl import cache_pkg::*, mem_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // processor port
  input  logic       req_valid,
  input  logic       req_write,
  input  addr_t      req_addr,
  input  word_t      req_wdata,
  output logic       ready,
  output logic       resp_valid,
  output word_t      resp_rdata,
  output logic       resp_hit,

  // line port towards the arbiter
  output logic       mem_valid,
  output logic       mem_write,
  output line_addr_t mem_addr,
  output line_t      mem_wdata,
  input  logic       mem_ready,
  input  logic       mem_rvalid,
  input  line_t      mem_rdata
);

  cache_state_t state;

  // arrays, indexed [set][way]
  line_t data_arr [`NUM_SETS][2];
  tag_t  tag_arr [`NUM_SETS][2];
  logic [`NUM_SETS-1:0][1:0] valid_arr;
  logic [`NUM_SETS-1:0][1:0] dirty_arr;
  logic [`NUM_SETS-1:0] lru_arr;  // way used last in each set

  tag_t      req_tag;
  set_idx_t  set_idx;
  word_off_t word_off;

  logic  hit0;
  logic  hit1;
  logic  hit;
  way_t  hit_way;
  way_t  victim_way;
  way_t  fill_way;      // way chosen on the miss
  logic  fill_pending;  // read issued, waiting for the line
  logic  missed;        // first lookup of this request missed
  line_t hit_line;
  line_t merged_line;

  assign req_tag  = req_addr[31:7];
  assign set_idx  = req_addr[6:4];
  assign word_off = req_addr[3:2];

  // both ways compared in parallel
  assign hit0    = valid_arr[set_idx][0] && (tag_arr[set_idx][0] == req_tag);
  assign hit1    = valid_arr[set_idx][1] && (tag_arr[set_idx][1] == req_tag);
  assign hit     = hit0 || hit1;
  assign hit_way = hit1;

  // empty way first, otherwise the one not used last
  always_comb begin
    if (!valid_arr[set_idx][0])
      victim_way = 1'b0;
    else if (!valid_arr[set_idx][1])
      victim_way = 1'b1;
    else
      victim_way = ~lru_arr[set_idx];
  end

  always_comb begin
    hit_line = data_arr[set_idx][hit_way];
    merged_line = hit_line;
    merged_line[word_off*32 +: 32] = req_wdata;  // write hit lands here
  end

  assign ready      = (state == idle);
  assign resp_valid = (state == compare_tag) && hit;
  assign resp_rdata = hit_line[word_off*32 +: 32];
  assign resp_hit   = !missed;

  assign mem_valid = (state == write_back) || ((state == allocate) && !fill_pending);
  assign mem_write = (state == write_back);
  assign mem_wdata = data_arr[set_idx][fill_way];

  always_comb begin
    if (state == write_back)
      mem_addr = {tag_arr[set_idx][fill_way], set_idx};  // victim line
    else
      mem_addr = {req_tag, set_idx};
  end

  // control state and status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= idle;
      valid_arr    <= '0;
      dirty_arr    <= '0;
      lru_arr      <= '0;
      fill_way     <= 1'b0;
      fill_pending <= 1'b0;
      missed       <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req_valid) begin
            state  <= compare_tag;
            missed <= 1'b0;
          end
        end
        compare_tag: begin
          if (hit) begin
            lru_arr[set_idx] <= hit_way;
            if (req_write)
              dirty_arr[set_idx][hit_way] <= 1'b1;
            state <= idle;
          end else begin
            missed   <= 1'b1;
            fill_way <= victim_way;
            if (valid_arr[set_idx][victim_way] && dirty_arr[set_idx][victim_way])
              state <= write_back;
            else
              state <= allocate;
          end
        end
        write_back: begin
          if (mem_ready)  // write accepted, memory finishes it on its own
            state <= allocate;
        end
        allocate: begin
          if (!fill_pending) begin
            if (mem_ready)
              fill_pending <= 1'b1;
          end else if (mem_rvalid) begin
            fill_pending                 <= 1'b0;
            valid_arr[set_idx][fill_way] <= 1'b1;
            dirty_arr[set_idx][fill_way] <= 1'b0;
            state                        <= compare_tag;  // looks up again, now hits
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // line data and tags
  always_ff @(posedge clk) begin
    if ((state == compare_tag) && hit && req_write)
      data_arr[set_idx][hit_way] <= merged_line;
    if ((state == allocate) && fill_pending && mem_rvalid) begin
      data_arr[set_idx][fill_way] <= mem_rdata;
      tag_arr[set_idx][fill_way]  <= req_tag;
    end
  end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import mem_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  logic       a_valid,
  input  logic       a_write,
  input  line_addr_t a_addr,
  input  line_t      a_wdata,
  output logic       a_ready,
  output logic       a_rvalid,

  input  logic       b_valid,
  input  logic       b_write,
  input  line_addr_t b_addr,
  input  line_t      b_wdata,
  output logic       b_ready,
  output logic       b_rvalid,

  output line_t      rdata,  // same line to both caches

  output logic       mem_valid,
  output logic       mem_write,
  output line_addr_t mem_addr,
  output line_t      mem_wdata,
  input  logic       mem_ready,
  input  logic       mem_rvalid,
  input  line_t      mem_rdata
);

  arb_state_t state;
  req_id_t    grant;       // owner of the running transaction
  req_id_t    last_grant;  // owner of the previous one
  req_id_t    sel;
  req_id_t    owner;

  // round robin between the two caches
  always_comb begin
    if (a_valid && b_valid)
      sel = ~last_grant;
    else if (b_valid)
      sel = 1'b1;
    else
      sel = 1'b0;
  end

  assign owner = (state == arb_idle) ? sel : grant;

  // nothing new reaches the memory while one transaction runs
  assign mem_valid = (state == arb_idle) && (a_valid || b_valid);
  assign mem_write = owner ? b_write : a_write;
  assign mem_addr  = owner ? b_addr : a_addr;
  assign mem_wdata = owner ? b_wdata : a_wdata;

  assign a_ready  = (state == arb_idle) && (owner == 1'b0) && mem_ready;
  assign b_ready  = (state == arb_idle) && (owner == 1'b1) && mem_ready;
  assign a_rvalid = (state == arb_busy) && (grant == 1'b0) && mem_rvalid;
  assign b_rvalid = (state == arb_busy) && (grant == 1'b1) && mem_rvalid;
  assign rdata    = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= arb_idle;
      grant      <= 1'b0;
      last_grant <= 1'b1;  // port a wins the first tie
    end else begin
      case (state)
        arb_idle: begin
          if (mem_valid && mem_ready) begin
            state <= arb_busy;
            grant <= sel;
          end
        end
        arb_busy: begin
          if (mem_ready) begin  // memory done
            state      <= arb_idle;
            last_grant <= grant;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

endmodule

//--- logic/line_memory.sv
`timescale 1ns/1ns
`include "cache_params.svh"

module line_memory import mem_pkg::*; #(
  parameter int LATENCY = `MEM_LATENCY
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       valid,
  input  logic       write,
  input  line_addr_t addr,
  input  line_t      wdata,
  output logic       ready,
  output logic       rvalid,
  output line_t      rdata
);

  localparam int IDX_W = $clog2(`MEM_LINES);
  localparam int CNT_W = $clog2(LATENCY + 1);

  mem_state_t state;
  line_t mem [`MEM_LINES];

  logic [CNT_W-1:0] count;  // busy cycles left after this one
  logic             op_write;
  logic [IDX_W-1:0] idx_q;
  line_t            wdata_q;
  logic             last_cycle;

  assign last_cycle = (state == mem_busy) && (count == '0);

  assign ready  = (state == mem_idle);
  assign rvalid = last_cycle && !op_write;
  assign rdata  = mem[idx_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= mem_idle;
      count    <= '0;
      op_write <= 1'b0;
      for (int i = 0; i < `MEM_LINES; i++)
        mem[i] <= '0;
    end else begin
      case (state)
        mem_idle: begin
          if (valid) begin
            state    <= mem_busy;
            count    <= CNT_W'(LATENCY - 1);
            op_write <= write;
          end
        end
        mem_busy: begin
          if (count == '0) begin
            state <= mem_idle;
            if (op_write)
              mem[idx_q] <= wdata_q;  // write takes effect at the end
          end else begin
            count <= count - 1'b1;
          end
        end
        default: state <= mem_idle;
      endcase
    end
  end

  // request payload, captured on accept
  always_ff @(posedge clk) begin
    if ((state == mem_idle) && valid) begin
      idx_q   <= addr[IDX_W-1:0];
      wdata_q <= wdata;
    end
  end

endmodule

//--- logic/cache_system.sv
`timescale 1ns/1ns

module cache_system import cache_pkg::*, mem_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  input  logic  a_req_valid,
  input  logic  a_req_write,
  input  addr_t a_req_addr,
  input  word_t a_req_wdata,
  output logic  a_ready,
  output logic  a_resp_valid,
  output word_t a_resp_rdata,
  output logic  a_resp_hit,

  input  logic  b_req_valid,
  input  logic  b_req_write,
  input  addr_t b_req_addr,
  input  word_t b_req_wdata,
  output logic  b_ready,
  output logic  b_resp_valid,
  output word_t b_resp_rdata,
  output logic  b_resp_hit
);

  // cache a to arbiter
  logic       a_mem_valid;
  logic       a_mem_write;
  line_addr_t a_mem_addr;
  line_t      a_mem_wdata;
  logic       a_mem_ready;
  logic       a_mem_rvalid;

  // cache b to arbiter
  logic       b_mem_valid;
  logic       b_mem_write;
  line_addr_t b_mem_addr;
  line_t      b_mem_wdata;
  logic       b_mem_ready;
  logic       b_mem_rvalid;

  line_t      line_rdata;  // broadcast fill data

  // arbiter to memory
  logic       m_valid;
  logic       m_write;
  line_addr_t m_addr;
  line_t      m_wdata;
  logic       m_ready;
  logic       m_rvalid;
  line_t      m_rdata;

  cache_ctrl cache_a_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (a_req_valid),
    .req_write  (a_req_write),
    .req_addr   (a_req_addr),
    .req_wdata  (a_req_wdata),
    .ready      (a_ready),
    .resp_valid (a_resp_valid),
    .resp_rdata (a_resp_rdata),
    .resp_hit   (a_resp_hit),
    .mem_valid  (a_mem_valid),
    .mem_write  (a_mem_write),
    .mem_addr   (a_mem_addr),
    .mem_wdata  (a_mem_wdata),
    .mem_ready  (a_mem_ready),
    .mem_rvalid (a_mem_rvalid),
    .mem_rdata  (line_rdata)
  );

  cache_ctrl cache_b_i (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (b_req_valid),
    .req_write  (b_req_write),
    .req_addr   (b_req_addr),
    .req_wdata  (b_req_wdata),
    .ready      (b_ready),
    .resp_valid (b_resp_valid),
    .resp_rdata (b_resp_rdata),
    .resp_hit   (b_resp_hit),
    .mem_valid  (b_mem_valid),
    .mem_write  (b_mem_write),
    .mem_addr   (b_mem_addr),
    .mem_wdata  (b_mem_wdata),
    .mem_ready  (b_mem_ready),
    .mem_rvalid (b_mem_rvalid),
    .mem_rdata  (line_rdata)
  );

  mem_arbiter arb_i (
    .clk        (clk),
    .reset      (reset),
    .a_valid    (a_mem_valid),
    .a_write    (a_mem_write),
    .a_addr     (a_mem_addr),
    .a_wdata    (a_mem_wdata),
    .a_ready    (a_mem_ready),
    .a_rvalid   (a_mem_rvalid),
    .b_valid    (b_mem_valid),
    .b_write    (b_mem_write),
    .b_addr     (b_mem_addr),
    .b_wdata    (b_mem_wdata),
    .b_ready    (b_mem_ready),
    .b_rvalid   (b_mem_rvalid),
    .rdata      (line_rdata),
    .mem_valid  (m_valid),
    .mem_write  (m_write),
    .mem_addr   (m_addr),
    .mem_wdata  (m_wdata),
    .mem_ready  (m_ready),
    .mem_rvalid (m_rvalid),
    .mem_rdata  (m_rdata)
  );

  line_memory mem_i (
    .clk    (clk),
    .reset  (reset),
    .valid  (m_valid),
    .write  (m_write),
    .addr   (m_addr),
    .wdata  (m_wdata),
    .ready  (m_ready),
    .rvalid (m_rvalid),
    .rdata  (m_rdata)
  );

endmodule

//--- verif/cache_system_sva.sv
`timescale 1ns/1ns

module cache_system_sva (
  input logic clk,
  input logic reset,
  input logic a_ready,
  input logic a_resp_valid,
  input logic b_ready,
  input logic b_resp_valid,
  input logic a_mem_valid,
  input logic b_mem_valid,
  input logic a_mem_ready,
  input logic b_mem_ready,
  input logic a_mem_rvalid,
  input logic b_mem_rvalid,
  input logic m_valid,
  input logic m_ready
);

  // failure count of each assertion
  int n_exclusive = 0;
  int n_serial = 0;
  int n_ready = 0;
  int n_pulse_a = 0;
  int n_pulse_b = 0;
  int error_count;

  logic a_in_service;  // line request of cache a accepted, memory not done yet
  logic b_in_service;

  assign error_count = n_exclusive + n_serial + n_ready + n_pulse_a + n_pulse_b;

  // a transaction runs from its accept until the memory is ready again
  always_ff @(posedge clk) begin
    if (reset) begin
      a_in_service <= 1'b0;
      b_in_service <= 1'b0;
    end else begin
      if (a_mem_valid && a_mem_ready)
        a_in_service <= 1'b1;
      else if (m_ready)
        a_in_service <= 1'b0;
      if (b_mem_valid && b_mem_ready)
        b_in_service <= 1'b1;
      else if (m_ready)
        b_in_service <= 1'b0;
    end
  end

  // no accept for one cache while the other is served, fill data only to the owner
  grant_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(a_in_service && b_mem_valid && b_mem_ready) &&
    !(b_in_service && a_mem_valid && a_mem_ready) &&
    !(a_mem_rvalid && !a_in_service) && !(b_mem_rvalid && !b_in_service))
    else begin
      n_exclusive++;
      $error("both caches served by the line memory at once");
    end

  // a new line request only reaches an idle memory
  mem_serial: assert property (@(posedge clk) disable iff (reset) m_valid |-> m_ready)
    else begin
      n_serial++;
      $error("line memory got a request while busy");
    end

  resp_not_ready: assert property (@(posedge clk) disable iff (reset)
    !(a_resp_valid && a_ready) && !(b_resp_valid && b_ready))
    else begin
      n_ready++;
      $error("resp_valid high together with ready");
    end

  pulse_a: assert property (@(posedge clk) disable iff (reset) a_resp_valid |=> !a_resp_valid)
    else begin
      n_pulse_a++;
      $error("a_resp_valid longer than one cycle");
    end

  pulse_b: assert property (@(posedge clk) disable iff (reset) b_resp_valid |=> !b_resp_valid)
    else begin
      n_pulse_b++;
      $error("b_resp_valid longer than one cycle");
    end

endmodule

bind cache_system cache_system_sva sva_i (
  .clk          (clk),
  .reset        (reset),
  .a_ready      (a_ready),
  .a_resp_valid (a_resp_valid),
  .b_ready      (b_ready),
  .b_resp_valid (b_resp_valid),
  .a_mem_valid  (a_mem_valid),
  .b_mem_valid  (b_mem_valid),
  .a_mem_ready  (a_mem_ready),
  .b_mem_ready  (b_mem_ready),
  .a_mem_rvalid (a_mem_rvalid),
  .b_mem_rvalid (b_mem_rvalid),
  .m_valid      (m_valid),
  .m_ready      (m_ready)
);

//--- verif/cache_system_tb.sv
`timescale 1ns/1ns
`include "cache_params.svh"

module cache_system_tb
  import cache_pkg::*, mem_pkg::*;
();

  localparam int NUM_ROWS = 24;
  localparam int TIMEOUT_MARGIN = 100;
  localparam int CYCLE_LIMIT = NUM_ROWS * 2 * (`MEM_LATENCY + 4) + TIMEOUT_MARGIN;

  localparam logic [1:0] PORT_A  = 2'b01;
  localparam logic [1:0] PORT_B  = 2'b10;
  localparam logic [1:0] PORT_AB = 2'b11;

  logic  clk;
  logic  reset;
  logic  a_req_valid;
  logic  a_req_write;
  addr_t a_req_addr;
  word_t a_req_wdata;
  logic  a_ready;
  logic  a_resp_valid;
  word_t a_resp_rdata;
  logic  a_resp_hit;
  logic  b_req_valid;
  logic  b_req_write;
  addr_t b_req_addr;
  word_t b_req_wdata;
  logic  b_ready;
  logic  b_resp_valid;
  word_t b_resp_rdata;
  logic  b_resp_hit;

  // stimulus table, one entry per step
  logic [1:0] row_ports [NUM_ROWS];
  logic       row_write [NUM_ROWS];
  addr_t      row_addr_a [NUM_ROWS];
  addr_t      row_addr_b [NUM_ROWS];
  word_t      row_wdata [NUM_ROWS];
  logic       row_hit_a [NUM_ROWS];
  logic       row_hit_b [NUM_ROWS];

  word_t  shadow [256];  // every word of lines 0 to 63
  integer seed = 32'h17599c64;
  int     cycle = 0;

  cache_system dut_i (.*);

  always #4 clk = ~clk;

  task automatic fail_run(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (dut_i.sva_i.error_count != 0)
      fail_run("a bound assertion on the cache system failed");
    else if (cycle >= CYCLE_LIMIT)
      fail_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_hit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic expect_level(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic compare_latency(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("Fail at %0t: %s = %0d cycles, expected %0d", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  function automatic logic [7:0] word_index(input addr_t addr);
    return addr[9:2];
  endfunction

  task automatic set_row(input int r, input logic [1:0] ports, input logic write,
                         input addr_t addr_a, input addr_t addr_b,
                         input logic hit_a, input logic hit_b);
    row_ports[r]  = ports;
    row_write[r]  = write;
    row_addr_a[r] = addr_a;
    row_addr_b[r] = addr_b;
    row_hit_a[r]  = hit_a;
    row_hit_b[r]  = hit_b;
  endtask

  // port a on lines 0..31, port b on lines 32..63
  task automatic fill_table();
    //      row port     wr    addr a         addr b         hit a hit b
    set_row(0,  PORT_A,  1'b0, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    set_row(1,  PORT_A,  1'b0, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    set_row(2,  PORT_A,  1'b1, 32'h0000_0014, 32'h0000_0000, 1'b0, 1'b0);
    set_row(3,  PORT_A,  1'b0, 32'h0000_0014, 32'h0000_0000, 1'b1, 1'b0);
    set_row(4,  PORT_A,  1'b0, 32'h0000_0018, 32'h0000_0000, 1'b1, 1'b0);
    // set 2 gets three tags, the third evicts the dirty LRU way
    set_row(5,  PORT_A,  1'b1, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0);
    set_row(6,  PORT_A,  1'b1, 32'h0000_00a4, 32'h0000_0000, 1'b0, 1'b0);
    set_row(7,  PORT_A,  1'b0, 32'h0000_0020, 32'h0000_0000, 1'b1, 1'b0);
    set_row(8,  PORT_A,  1'b1, 32'h0000_0128, 32'h0000_0000, 1'b0, 1'b0);
    set_row(9,  PORT_A,  1'b0, 32'h0000_0020, 32'h0000_0000, 1'b1, 1'b0);
    set_row(10, PORT_A,  1'b0, 32'h0000_00a4, 32'h0000_0000, 1'b0, 1'b0);
    set_row(11, PORT_A,  1'b0, 32'h0000_0128, 32'h0000_0000, 1'b0, 1'b0);
    set_row(12, PORT_A,  1'b0, 32'h0000_0020, 32'h0000_0000, 1'b0, 1'b0);
    // both ports contend for the line memory
    set_row(13, PORT_AB, 1'b0, 32'h0000_0030, 32'h0000_0230, 1'b0, 1'b0);
    set_row(14, PORT_AB, 1'b1, 32'h0000_0044, 32'h0000_0244, 1'b0, 1'b0);
    set_row(15, PORT_AB, 1'b0, 32'h0000_0044, 32'h0000_0244, 1'b1, 1'b1);
    set_row(16, PORT_B,  1'b1, 32'h0000_0000, 32'h0000_0250, 1'b0, 1'b0);
    set_row(17, PORT_B,  1'b1, 32'h0000_0000, 32'h0000_02d0, 1'b0, 1'b0);
    set_row(18, PORT_B,  1'b1, 32'h0000_0000, 32'h0000_0350, 1'b0, 1'b0);
    set_row(19, PORT_AB, 1'b0, 32'h0000_01c4, 32'h0000_0250, 1'b0, 1'b0);
    set_row(20, PORT_AB, 1'b0, 32'h0000_00c4, 32'h0000_02d0, 1'b0, 1'b0);  // two write-backs
    set_row(21, PORT_AB, 1'b0, 32'h0000_0044, 32'h0000_0350, 1'b0, 1'b0);
    set_row(22, PORT_AB, 1'b0, 32'h0000_0014, 32'h0000_0244, 1'b1, 1'b1);
    set_row(23, PORT_AB, 1'b0, 32'h0000_0000, 32'h0000_0204, 1'b1, 1'b0);
  endtask

  // looks at one port on a falling edge
  task automatic watch_port(input string port, input logic resp_valid, input logic ready,
                            input word_t rdata, input logic hit, input logic exp_hit,
                            input logic is_read, input word_t exp_data,
                            inout logic pending, inout logic accepted,
                            inout int acc_cycle, output logic done);
    done = 1'b0;
    if (resp_valid) begin
      if (!pending)
        fail_run($sformatf("port %s responded with no request outstanding", port));
      else if (!accepted)
        fail_run($sformatf("port %s responded before it accepted the request", port));
      else begin
        check_hit($sformatf("%s_resp_hit", port), hit, exp_hit);
        if (is_read)
          check_word($sformatf("%s_resp_rdata", port), rdata, exp_data);
        if (exp_hit)
          compare_latency($sformatf("%s hit latency", port), cycle - acc_cycle, 1);
        pending = 1'b0;
        done    = 1'b1;
      end
    end else if (pending) begin
      if (!accepted) begin
        if (ready) begin  // taken on the next rising edge
          accepted  = 1'b1;
          acc_cycle = cycle;
        end
      end else if (ready) begin
        fail_run($sformatf("port %s became ready before its response", port));
      end
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic run_row(input int r);
    logic  a_pending;
    logic  b_pending;
    logic  a_accepted;
    logic  b_accepted;
    logic  a_done;
    logic  b_done;
    int    a_acc_cycle;
    int    b_acc_cycle;
    word_t a_expect;
    word_t b_expect;
    a_pending   = row_ports[r][0];
    b_pending   = row_ports[r][1];
    a_accepted  = 1'b0;
    b_accepted  = 1'b0;
    a_acc_cycle = 0;
    b_acc_cycle = 0;
    a_expect    = shadow[word_index(row_addr_a[r])];
    b_expect    = shadow[word_index(row_addr_b[r])];
    if (a_pending) begin
      a_req_valid = 1'b1;
      a_req_write = row_write[r];
      a_req_addr  = row_addr_a[r];
      a_req_wdata = row_wdata[r];
      if (row_write[r])
        shadow[word_index(row_addr_a[r])] = row_wdata[r];
    end
    if (b_pending) begin
      b_req_valid = 1'b1;
      b_req_write = row_write[r];
      b_req_addr  = row_addr_b[r];
      b_req_wdata = row_wdata[r];
      if (row_write[r])
        shadow[word_index(row_addr_b[r])] = row_wdata[r];
    end
    while (a_pending || b_pending) begin
      @(negedge clk);
      watch_port("a", a_resp_valid, a_ready, a_resp_rdata, a_resp_hit, row_hit_a[r],
                 !row_write[r], a_expect, a_pending, a_accepted, a_acc_cycle, a_done);
      watch_port("b", b_resp_valid, b_ready, b_resp_rdata, b_resp_hit, row_hit_b[r],
                 !row_write[r], b_expect, b_pending, b_accepted, b_acc_cycle, b_done);
      @(posedge clk);
      #1;
      if (a_done)
        a_req_valid = 1'b0;
      if (b_done)
        b_req_valid = 1'b0;
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    a_req_valid = 1'b0;
    a_req_write = 1'b0;
    a_req_addr  = '0;
    a_req_wdata = '0;
    b_req_valid = 1'b0;
    b_req_write = 1'b0;
    b_req_addr  = '0;
    b_req_wdata = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = '0;  // line memory clears on reset
    fill_table();
    for (int r = 0; r < NUM_ROWS; r++)
      row_wdata[r] = $random(seed);

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    expect_level("a_ready", a_ready, 1'b1);
    expect_level("b_ready", b_ready, 1'b1);
    expect_level("a_resp_valid", a_resp_valid, 1'b0);
    expect_level("b_resp_valid", b_resp_valid, 1'b0);
    @(posedge clk);
    #1;

    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);

    @(negedge clk);
    if (dut_i.sva_i.error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Error at %0t: %0d assertion failures", $time, dut_i.sva_i.error_count);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

//--- files.f
+incdir+logic
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_ctrl.sv
logic/mem_arbiter.sv
logic/line_memory.sv
logic/cache_system.sv
verif/cache_system_sva.sv
verif/cache_system_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= cache_system_tb
FILELIST    ?= files.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing --assert
SIM_ARGS    ?= +verilator+error+limit+100
FAIL_MSG    ?= FAIL: see errors above
PASS_MSG    ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
